// File: design/csr_pkg.sv
`default_nettype none

package csr_pkg;

  localparam int XLEN        = 32;  // Data word width
  localparam int CNT_W       = 64;  // Counter width
  localparam int CAUSE_W     = 6;   // Stored cause, bit 5 flags an interrupt
  localparam int HPM_EVENT_W = 16;  // Selectable event bits

  // Machine-mode CSR addresses
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MHPMEVENT3    = 12'h323,  // First selector, others follow by offset
    CSR_MHPMEVENT4    = 12'h324,
    CSR_MHPMEVENT31   = 12'h33F,  // Last selector
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,  // Counter low words from here
    CSR_MINSTRET      = 12'hB02,
    CSR_MHPMCOUNTER3  = 12'hB03,
    CSR_MHPMCOUNTER4  = 12'hB04,
    CSR_MHPMCOUNTER31 = 12'hB1F,
    CSR_MCYCLEH       = 12'hB80,  // Counter high words from here
    CSR_MINSTRETH     = 12'hB82,
    CSR_MHPMCOUNTER3H = 12'hB83,
    CSR_MHPMCOUNTER4H = 12'hB84,
    CSR_MHPMCOUNTER31H = 12'hB9F,
    CSR_MVENDORID     = 12'hF11,
    CSR_MARCHID       = 12'hF12,
    CSR_MIMPID        = 12'hF13,
    CSR_MHARTID       = 12'hF14
  } csr_num_e;

  // Access operation from the pipeline
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  localparam logic [XLEN-1:0] IRQ_MASK = 32'hFFFF_0888;  // Fast irqs, MEI, MTI, MSI

  localparam logic [XLEN-1:0] MISA_VALUE = (32'd1 << 30)  // MXL, RV32
                                         | (32'd1 << 20)  // U
                                         | (32'd1 << 12)  // M
                                         | (32'd1 << 8)   // I
                                         | (32'd1 << 5)   // F
                                         | (32'd1 << 2);  // C

  localparam logic [XLEN-1:0] MVENDORID_VALUE = 32'h0000_0602;  // Bank 0xC, offset 0x02
  localparam logic [XLEN-1:0] MARCHID_VALUE   = 32'd4;
  localparam logic [XLEN-1:0] MIMPID_VALUE    = 32'd1;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11;  // Two bits, fixed machine mode

  localparam logic [1:0] MTVEC_MODE_RESET = 2'b01;  // Vectored after reset

  // Event indices, others reserved
  localparam int EVT_CYCLE    = 0;
  localparam int EVT_INSTRET  = 1;
  localparam int EVT_LD_STALL = 2;
  localparam int EVT_LOAD     = 5;
  localparam int EVT_STORE    = 6;
  localparam int EVT_BRANCH   = 8;

endpackage

`default_nettype wire

// File: design/csr_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_bus_if
  import csr_pkg::*;
();

  csr_num_e        addr;        // Access address
  logic [XLEN-1:0] wdata;       // Resolved write data
  logic            we;          // Write strobe, low on READ
  logic [XLEN-1:0] trap_rdata;  // Trap and identity registers
  logic [XLEN-1:0] hpm_rdata;   // Counter block

  modport access (output addr, wdata, we, input trap_rdata, hpm_rdata);
  modport trap (input addr, wdata, we, output trap_rdata);
  modport hpm (input addr, wdata, we, output hpm_rdata);

endinterface

`default_nettype wire

// File: design/csr_access.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access
  import csr_pkg::*;
(
  input  csr_op_e          csr_op_i,     // Operation from pipeline
  input  logic [XLEN-1:0]  csr_wdata_i,  // Operand from pipeline
  input  csr_num_e         csr_addr_i,   // Target register
  output logic [XLEN-1:0]  csr_rdata_o,  // Current value, same cycle
  csr_bus_if.access        bus
);

  logic [XLEN-1:0] rdata;  // Merged read word

  // Units return zero outside their own range
  assign rdata       = bus.trap_rdata | bus.hpm_rdata;
  assign csr_rdata_o = rdata;
  assign bus.addr    = csr_addr_i;

  always_comb begin  // Resolve op into write data
    bus.wdata = csr_wdata_i;
    bus.we    = 1'b1;
    case (csr_op_i)
      CSR_OP_WRITE: bus.wdata = csr_wdata_i;
      CSR_OP_SET:   bus.wdata = rdata | csr_wdata_i;   // Set the given bits
      CSR_OP_CLEAR: bus.wdata = rdata & ~csr_wdata_i;  // Clear the given bits
      CSR_OP_READ:  bus.we    = 1'b0;                  // Plain read
      default:      bus.we    = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/csr_trap_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs
  import csr_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  csr_bus_if.trap            bus,
  input  logic [XLEN-1:0]    hart_id_i,
  input  logic [XLEN-1:0]    mip_i,             // Pending irqs, read only
  input  logic [XLEN-1:0]    mtvec_addr_i,      // Boot vector
  input  logic               csr_mtvec_init_i,  // Load mtvec from boot vector
  input  logic [XLEN-1:0]    pc_if_i,
  input  logic [XLEN-1:0]    pc_id_i,
  input  logic [XLEN-1:0]    pc_ex_i,
  input  logic               csr_save_if_i,
  input  logic               csr_save_id_i,
  input  logic               csr_save_ex_i,
  input  logic               csr_save_cause_i,  // Trap entry
  input  logic               csr_restore_mret_i,
  input  logic [CAUSE_W-1:0] csr_cause_i,
  output logic [23:0]        mtvec_o,
  output logic [1:0]         mtvec_mode_o,
  output logic [XLEN-1:0]    mepc_o,
  output logic [XLEN-1:0]    mie_bypass_o,
  output logic               m_irq_enable_o
);

  logic               mstatus_mie_q, mstatus_mie_n;
  logic               mstatus_mpie_q, mstatus_mpie_n;
  logic [XLEN-1:0]    mie_q, mie_n;
  logic [XLEN-1:0]    mepc_q, mepc_n;
  logic [XLEN-1:0]    mscratch_q, mscratch_n;
  logic [CAUSE_W-1:0] mcause_q, mcause_n;
  logic [23:0]        mtvec_q, mtvec_n;
  logic [1:0]         mtvec_mode_q, mtvec_mode_n;
  logic [XLEN-1:0]    mstatus_rd;    // Assembled mstatus view
  logic [XLEN-1:0]    exception_pc;  // PC saved on trap

  always_comb begin
    mstatus_rd                      = '0;
    mstatus_rd[MSTATUS_MIE_BIT]     = mstatus_mie_q;
    mstatus_rd[MSTATUS_MPIE_BIT]    = mstatus_mpie_q;
    mstatus_rd[MSTATUS_MPP_LO +: 2] = 2'b11;  // Always machine mode
  end

  always_comb begin  // Own addresses only
    case (bus.addr)
      CSR_MSTATUS:   bus.trap_rdata = mstatus_rd;
      CSR_MISA:      bus.trap_rdata = MISA_VALUE;
      CSR_MIE:       bus.trap_rdata = mie_q;
      CSR_MTVEC:     bus.trap_rdata = {mtvec_q, 6'h0, mtvec_mode_q};
      CSR_MSCRATCH:  bus.trap_rdata = mscratch_q;
      CSR_MEPC:      bus.trap_rdata = mepc_q;
      CSR_MCAUSE:    bus.trap_rdata = {mcause_q[5], 26'b0, mcause_q[4:0]};  // Irq flag to MSB
      CSR_MIP:       bus.trap_rdata = mip_i;
      CSR_MHARTID:   bus.trap_rdata = hart_id_i;
      CSR_MVENDORID: bus.trap_rdata = MVENDORID_VALUE;
      CSR_MARCHID:   bus.trap_rdata = MARCHID_VALUE;
      CSR_MIMPID:    bus.trap_rdata = MIMPID_VALUE;
      default:       bus.trap_rdata = '0;
    endcase
  end

  always_comb begin  // Trap PC select, ID stage by default
    case (1'b1)
      csr_save_if_i: exception_pc = pc_if_i;
      csr_save_id_i: exception_pc = pc_id_i;
      csr_save_ex_i: exception_pc = pc_ex_i;
      default:       exception_pc = pc_id_i;
    endcase
  end

  always_comb begin  // Next state
    mstatus_mie_n  = mstatus_mie_q;
    mstatus_mpie_n = mstatus_mpie_q;
    mie_n          = mie_q;
    mepc_n         = mepc_q;
    mscratch_n     = mscratch_q;
    mcause_n       = mcause_q;
    mtvec_n        = csr_mtvec_init_i ? mtvec_addr_i[31:8] : mtvec_q;  // Boot load
    mtvec_mode_n   = mtvec_mode_q;
    if (bus.we) begin
      case (bus.addr)
        CSR_MSTATUS: begin
          mstatus_mie_n  = bus.wdata[MSTATUS_MIE_BIT];
          mstatus_mpie_n = bus.wdata[MSTATUS_MPIE_BIT];
        end
        CSR_MIE:      mie_n      = bus.wdata & IRQ_MASK;
        CSR_MTVEC: begin
          mtvec_n      = bus.wdata[31:8];
          mtvec_mode_n = {1'b0, bus.wdata[0]};  // Direct or vectored
        end
        CSR_MSCRATCH: mscratch_n = bus.wdata;
        CSR_MEPC:     mepc_n     = {bus.wdata[XLEN-1:1], 1'b0};  // Halfword aligned
        CSR_MCAUSE:   mcause_n   = {bus.wdata[31], bus.wdata[4:0]};
        default: ;
      endcase
    end
    if (csr_save_cause_i) begin  // Trap entry overrides a write
      mepc_n         = {exception_pc[XLEN-1:1], 1'b0};
      mcause_n       = csr_cause_i;
      mstatus_mpie_n = mstatus_mie_q;
      mstatus_mie_n  = 1'b0;
    end else if (csr_restore_mret_i) begin
      mstatus_mie_n  = mstatus_mpie_q;
      mstatus_mpie_n = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_q          <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
      mtvec_q        <= '0;
      mtvec_mode_q   <= MTVEC_MODE_RESET;
    end else begin
      mstatus_mie_q  <= mstatus_mie_n;
      mstatus_mpie_q <= mstatus_mpie_n;
      mie_q          <= mie_n;
      mepc_q         <= mepc_n;
      mcause_q       <= mcause_n;
      mtvec_q        <= mtvec_n;
      mtvec_mode_q   <= mtvec_mode_n;
    end
  end

  always_ff @(posedge clk) begin  // Scratch word
    mscratch_q <= mscratch_n;
  end

  // New mie seen by the irq controller in the write cycle
  assign mie_bypass_o   = (bus.we && bus.addr == CSR_MIE) ? (bus.wdata & IRQ_MASK) : mie_q;
  assign m_irq_enable_o = mstatus_mie_q;
  assign mtvec_o        = mtvec_q;
  assign mtvec_mode_o   = mtvec_mode_q;
  assign mepc_o         = mepc_q;

endmodule

`default_nettype wire

// File: design/hpm_counter.sv
`timescale 1ns/1ps
`default_nettype none

module hpm_counter
  import csr_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_lo_i,  // Write low word
  input  logic             wr_hi_i,  // Write high word
  input  logic             inc_i,    // Count one
  input  logic [XLEN-1:0]  wdata_i,
  output logic [CNT_W-1:0] count_o
);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (wr_lo_i) begin
      count_q[XLEN-1:0] <= wdata_i;  // Write beats increment
    end else if (wr_hi_i) begin
      count_q[CNT_W-1:XLEN] <= wdata_i;
    end else if (inc_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

endmodule

`default_nettype wire

// File: design/hpm_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hpm_unit
  import csr_pkg::*;
#(
  parameter int N_HPM_COUNTERS = 1  // Programmable counters, 1 to 29
) (
  input  logic                   clk,
  input  logic                   rst_n,
  csr_bus_if.hpm                 bus,
  input  logic [HPM_EVENT_W-1:0] hpm_event_i
);

  localparam int NCNT = N_HPM_COUNTERS + 2;  // Plus mcycle and minstret

  logic [NCNT-1:0]                            inhibit_q;  // Packed, no time bit
  logic [N_HPM_COUNTERS-1:0][HPM_EVENT_W-1:0] evt_sel_q;  // mhpmevent selectors
  logic [NCNT-1:0][CNT_W-1:0]                 count;
  logic [NCNT-1:0]                            sel_lo;     // Low word addressed
  logic [NCNT-1:0]                            sel_hi;     // High word addressed
  logic [NCNT-1:0]                            inc;
  logic [HPM_EVENT_W-1:0]                     events;     // Defined events only

  // Counter slot to CSR offset, skipping the time slot
  function automatic int cnt_off(input int k);
    return (k == 0) ? 0 : k + 1;
  endfunction

  always_comb begin
    events               = '0;
    events[EVT_CYCLE]    = 1'b1;  // Cycle event always on
    events[EVT_INSTRET]  = hpm_event_i[EVT_INSTRET];
    events[EVT_LD_STALL] = hpm_event_i[EVT_LD_STALL];
    events[EVT_LOAD]     = hpm_event_i[EVT_LOAD];
    events[EVT_STORE]    = hpm_event_i[EVT_STORE];
    events[EVT_BRANCH]   = hpm_event_i[EVT_BRANCH];
  end

  for (genvar k = 0; k < NCNT; k++) begin : gen_cnt
    assign sel_lo[k] = (bus.addr == 12'(CSR_MCYCLE + cnt_off(k)));
    assign sel_hi[k] = (bus.addr == 12'(CSR_MCYCLEH + cnt_off(k)));
    if (k == 0) begin : gen_mcycle
      assign inc[k] = !inhibit_q[k];
    end else if (k == 1) begin : gen_minstret
      assign inc[k] = !inhibit_q[k] && events[EVT_INSTRET];
    end else begin : gen_mhpm
      assign inc[k] = !inhibit_q[k] && |(evt_sel_q[k-2] & events);  // Any selected event
    end
    hpm_counter counter_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_lo_i (bus.we && sel_lo[k]),
      .wr_hi_i (bus.we && sel_hi[k]),
      .inc_i   (inc[k]),
      .wdata_i (bus.wdata),
      .count_o (count[k])
    );
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inhibit_q <= '1;  // All counters stopped
      evt_sel_q <= '0;
    end else if (bus.we) begin
      if (bus.addr == CSR_MCOUNTINHIBIT) begin
        for (int k = 0; k < NCNT; k++) begin
          inhibit_q[k] <= bus.wdata[cnt_off(k)];
        end
      end
      for (int j = 0; j < N_HPM_COUNTERS; j++) begin
        if (bus.addr == 12'(CSR_MHPMEVENT3 + j)) begin
          evt_sel_q[j] <= bus.wdata[HPM_EVENT_W-1:0];
        end
      end
    end
  end

  always_comb begin  // Read mux, zero outside range
    bus.hpm_rdata = '0;
    for (int k = 0; k < NCNT; k++) begin
      if (sel_lo[k]) bus.hpm_rdata = count[k][XLEN-1:0];
      if (sel_hi[k]) bus.hpm_rdata = count[k][CNT_W-1:XLEN];
    end
    for (int j = 0; j < N_HPM_COUNTERS; j++) begin
      if (bus.addr == 12'(CSR_MHPMEVENT3 + j)) bus.hpm_rdata = XLEN'(evt_sel_q[j]);
    end
    if (bus.addr == CSR_MCOUNTINHIBIT) begin
      for (int k = 0; k < NCNT; k++) begin
        bus.hpm_rdata[cnt_off(k)] = inhibit_q[k];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top
  import csr_pkg::*;
#(
  parameter int N_HPM_COUNTERS = 1
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [XLEN-1:0]        hart_id_i,
  input  csr_num_e               csr_addr_i,
  input  csr_op_e                csr_op_i,
  input  logic [XLEN-1:0]        csr_wdata_i,
  output logic [XLEN-1:0]        csr_rdata_o,
  input  logic [XLEN-1:0]        mtvec_addr_i,
  input  logic                   csr_mtvec_init_i,
  output logic [23:0]            mtvec_o,
  output logic [1:0]             mtvec_mode_o,
  output logic [XLEN-1:0]        mepc_o,
  output logic [XLEN-1:0]        mie_bypass_o,
  input  logic [XLEN-1:0]        mip_i,
  output logic                   m_irq_enable_o,
  input  logic [XLEN-1:0]        pc_if_i,
  input  logic [XLEN-1:0]        pc_id_i,
  input  logic [XLEN-1:0]        pc_ex_i,
  input  logic                   csr_save_if_i,
  input  logic                   csr_save_id_i,
  input  logic                   csr_save_ex_i,
  input  logic                   csr_save_cause_i,
  input  logic                   csr_restore_mret_i,
  input  logic [CAUSE_W-1:0]     csr_cause_i,
  input  logic [HPM_EVENT_W-1:0] hpm_event_i  // Cycle bit unused
);

  csr_bus_if csr_bus ();  // Access logic to register units

  csr_access access_inst (
    .csr_op_i    (csr_op_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_addr_i  (csr_addr_i),
    .csr_rdata_o (csr_rdata_o),
    .bus         (csr_bus)
  );

  csr_trap_regs trap_regs_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .bus                (csr_bus),
    .hart_id_i          (hart_id_i),
    .mip_i              (mip_i),
    .mtvec_addr_i       (mtvec_addr_i),
    .csr_mtvec_init_i   (csr_mtvec_init_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .pc_ex_i            (pc_ex_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_save_ex_i      (csr_save_ex_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_cause_i        (csr_cause_i),
    .mtvec_o            (mtvec_o),
    .mtvec_mode_o       (mtvec_mode_o),
    .mepc_o             (mepc_o),
    .mie_bypass_o       (mie_bypass_o),
    .m_irq_enable_o     (m_irq_enable_o)
  );

  hpm_unit #(
    .N_HPM_COUNTERS (N_HPM_COUNTERS)
  ) hpm_unit_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (csr_bus),
    .hpm_event_i (hpm_event_i)
  );

endmodule

`default_nettype wire

// File: testbench/csr_tb_assert.sv
`timescale 1ns/1ps
`default_nettype none

module csr_tb_assert (
  input logic        clk,
  input logic        rst_n,
  input logic        save_cause_i,  // Trap entry strobe
  input logic        irq_enable_i,  // mstatus.mie
  input logic [31:0] mepc_i,
  input logic [1:0]  mtvec_mode_i
);

  int fail_cnt = 0;  // Summed into the final count by csr_tb

  mepc_aligned: assert property (@(posedge clk) disable iff (!rst_n) mepc_i[0] == 1'b0)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("mepc_o bit 0 is set");
    end

  // Trap entry always disables interrupts
  irq_off_after_trap: assert property (@(posedge clk) disable iff (!rst_n)
                                       save_cause_i |=> !irq_enable_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("m_irq_enable_o still high after trap entry");
    end

  mode_hi_zero: assert property (@(posedge clk) disable iff (!rst_n) mtvec_mode_i[1] == 1'b0)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("mtvec_mode_o high bit is set");
    end

endmodule

bind csr_top csr_tb_assert invariant_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .save_cause_i (csr_save_cause_i),
  .irq_enable_i (m_irq_enable_o),
  .mepc_i       (mepc_o),
  .mtvec_mode_i (mtvec_mode_o)
);

`default_nettype wire

// File: testbench/csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_tb
  import csr_pkg::*;
();

  logic clk;
  logic rst_n;
  logic [31:0] hart_id;
  logic [31:0] mip;
  csr_num_e csr_addr;
  csr_op_e csr_op;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;
  logic [31:0] mtvec_addr;
  logic mtvec_init;
  logic [23:0] mtvec;
  logic [1:0] mtvec_mode;
  logic [31:0] mepc;
  logic [31:0] mie_bypass;
  logic irq_enable;
  logic [31:0] pc_if, pc_id, pc_ex;
  logic save_if, save_id, save_ex, save_cause, restore_mret;
  logic [CAUSE_W-1:0] cause;
  logic [HPM_EVENT_W-1:0] hpm_event;
  logic [31:0] seed = 32'h2ce7_894d;
  int err_cnt = 0;

  csr_top #(.N_HPM_COUNTERS(1)) csr_top_inst (
    .clk(clk), .rst_n(rst_n), .hart_id_i(hart_id),
    .csr_addr_i(csr_addr), .csr_op_i(csr_op), .csr_wdata_i(csr_wdata),
    .csr_rdata_o(csr_rdata), .mtvec_addr_i(mtvec_addr), .csr_mtvec_init_i(mtvec_init),
    .mtvec_o(mtvec), .mtvec_mode_o(mtvec_mode), .mepc_o(mepc), .mie_bypass_o(mie_bypass),
    .mip_i(mip), .m_irq_enable_o(irq_enable), .pc_if_i(pc_if), .pc_id_i(pc_id),
    .pc_ex_i(pc_ex), .csr_save_if_i(save_if), .csr_save_id_i(save_id),
    .csr_save_ex_i(save_ex), .csr_save_cause_i(save_cause),
    .csr_restore_mret_i(restore_mret), .csr_cause_i(cause), .hpm_event_i(hpm_event)
  );

  always #10 clk = ~clk;  // 20 ns period

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
    return seed;
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      err_cnt++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // One access cycle, then back to READ
  task automatic xfer(input csr_op_e op, input csr_num_e addr, input logic [31:0] wdata,
                      output logic [31:0] rdata, output logic [31:0] bypass);
    @(negedge clk);
    csr_op    = op;
    csr_addr  = addr;
    csr_wdata = wdata;
    #1;
    rdata  = csr_rdata;  // Combinational, settled
    bypass = mie_bypass;
    @(negedge clk);
    csr_op = CSR_OP_READ;
  endtask

  task automatic write_csr(input csr_num_e addr, input logic [31:0] wdata);
    logic [31:0] rd, byp;
    xfer(CSR_OP_WRITE, addr, wdata, rd, byp);
  endtask

  task automatic expect_csr(input csr_num_e addr, input logic [31:0] exp, input string name);
    logic [31:0] rd, byp;
    xfer(CSR_OP_READ, addr, 32'h0, rd, byp);
    check_word(name, exp, rd);
  endtask

  task automatic read64(input csr_num_e lo, input csr_num_e hi, output logic [63:0] val);
    logic [31:0] rl, rh, byp;
    xfer(CSR_OP_READ, lo, 32'h0, rl, byp);
    xfer(CSR_OP_READ, hi, 32'h0, rh, byp);
    val = {rh, rl};
  endtask

  task automatic wait_irq_enable(input logic val);
    int n;
    n = 0;
    while (irq_enable !== val && n < 8) begin  // Bounded poll
      @(negedge clk);
      n++;
    end
    if (irq_enable !== val) begin
      err_cnt++;
      $display("Timed out waiting for m_irq_enable_o to become %0b", val);
    end
  endtask

  initial begin
    #200us;  // Watchdog
    $display("Watchdog expired before the test sequence finished");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [31:0] model [3];
    logic [31:0] keep [3];
    csr_num_e regs [3];
    string names [3];
    string cnt_names [3];
    csr_num_e cnt_lo [3];
    csr_num_e cnt_hi [3];
    logic [63:0] start [3];
    logic [63:0] v64, v64b, exp_cyc;
    logic [31:0] r, w, rd, byp, res, exp_pc;
    logic mie_bit;
    csr_op_e op;
    int sel, n_instret, n_load, total;
    regs      = '{CSR_MSCRATCH, CSR_MIE, CSR_MEPC};
    names     = '{"mscratch", "mie", "mepc"};
    keep      = '{32'hFFFF_FFFF, IRQ_MASK, 32'hFFFF_FFFE};  // Writable bits per register
    cnt_names = '{"mcycle", "minstret", "mhpmcounter3"};
    cnt_lo    = '{CSR_MCYCLE, CSR_MINSTRET, CSR_MHPMCOUNTER3};
    cnt_hi    = '{CSR_MCYCLEH, CSR_MINSTRETH, CSR_MHPMCOUNTER3H};
    clk = 1'b0;
    rst_n = 1'b0;
    hart_id = next_rand();
    mip = next_rand();
    csr_addr = CSR_MSTATUS;
    csr_op = CSR_OP_READ;
    csr_wdata = '0;
    mtvec_addr = '0;
    mtvec_init = 1'b0;
    {pc_if, pc_id, pc_ex} = '0;
    {save_if, save_id, save_ex, save_cause, restore_mret} = '0;
    cause = '0;
    hpm_event = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    expect_csr(CSR_MSTATUS, 32'h0000_1800, "mstatus");  // MPP fixed at 11
    expect_csr(CSR_MISA, 32'h4010_1124, "misa");        // RV32 IMFCU
    expect_csr(CSR_MHARTID, hart_id, "mhartid");
    expect_csr(CSR_MIP, mip, "mip");
    expect_csr(CSR_MCOUNTINHIBIT, 32'hD, "mcountinhibit");
    check_word("mtvec_mode_o", 32'h1, {30'b0, mtvec_mode});
    check_word("m_irq_enable_o", 32'h0, {31'b0, irq_enable});
    check_word("mepc_o", 32'h0, mepc);

    for (int k = 0; k < 3; k++) begin  // Known start, mscratch has no reset
      w = next_rand();
      write_csr(regs[k], w);
      model[k] = w & keep[k];
    end
    for (int i = 0; i < 32; i++) begin
      r   = next_rand();
      sel = r % 3;
      op  = csr_op_e'(r[5:4]);
      w   = next_rand();
      xfer(op, regs[sel], w, rd, byp);
      check_word(names[sel], model[sel], rd);
      case (op)
        CSR_OP_WRITE: res = w;
        CSR_OP_SET:   res = model[sel] | w;
        CSR_OP_CLEAR: res = model[sel] & ~w;
        default:      res = model[sel];
      endcase
      if (op != CSR_OP_READ) begin
        model[sel] = res & keep[sel];
        if (sel == 1) check_word("mie_bypass_o", model[sel], byp);
      end
    end
    for (int k = 0; k < 3; k++) expect_csr(regs[k], model[k], names[k]);

    for (int s = 0; s < 4; s++) begin  // IF, ID, EX, then none
      r = next_rand();
      mie_bit = s[0];  // Traps alternate between mie low and high
      write_csr(CSR_MSTATUS, {28'b0, mie_bit, 3'b0});
      pc_if = next_rand();
      pc_id = next_rand();
      pc_ex = next_rand();
      exp_pc = (s == 0) ? pc_if : (s == 2) ? pc_ex : pc_id;
      @(negedge clk);
      save_if    = (s == 0);
      save_id    = (s == 1);
      save_ex    = (s == 2);
      save_cause = 1'b1;
      cause      = r[13:8];
      @(negedge clk);
      {save_if, save_id, save_ex, save_cause} = '0;
      check_word("mepc_o", {exp_pc[31:1], 1'b0}, mepc);
      check_word("m_irq_enable_o", 32'h0, {31'b0, irq_enable});
      expect_csr(CSR_MCAUSE, {r[13], 26'b0, r[12:8]}, "mcause");
      expect_csr(CSR_MSTATUS, 32'h1800 | (32'(mie_bit) << 7), "mstatus");
      @(negedge clk);
      restore_mret = 1'b1;
      @(negedge clk);
      restore_mret = 1'b0;
      wait_irq_enable(mie_bit);
      expect_csr(CSR_MSTATUS, 32'h1880 | (32'(mie_bit) << 3), "mstatus");
    end

    @(negedge clk);
    mtvec_addr = next_rand();
    mtvec_init = 1'b1;
    @(negedge clk);
    mtvec_init = 1'b0;
    check_word("mtvec_o", {8'b0, mtvec_addr[31:8]}, {8'b0, mtvec});
    w = (next_rand() | 32'h2) & ~32'h1;  // Mode field 10 in the data, so mode drops to 00
    write_csr(CSR_MTVEC, w);
    check_word("mtvec_o", {8'b0, w[31:8]}, {8'b0, mtvec});
    check_word("mtvec_mode_o", {31'b0, w[0]}, {30'b0, mtvec_mode});
    expect_csr(CSR_MTVEC, {w[31:8], 7'b0, w[0]}, "mtvec");

    for (int k = 0; k < 3; k++) begin  // Inhibited, writes stick
      start[k] = {next_rand(), next_rand()};
      write_csr(cnt_lo[k], start[k][31:0]);
      write_csr(cnt_hi[k], start[k][63:32]);
      read64(cnt_lo[k], cnt_hi[k], v64);
      check_word({cnt_names[k], "_lo"}, start[k][31:0], v64[31:0]);
      check_word({cnt_names[k], "_hi"}, start[k][63:32], v64[63:32]);
    end
    write_csr(CSR_MHPMEVENT3, 32'h1 << EVT_LOAD);
    expect_csr(CSR_MHPMEVENT3, 32'h1 << EVT_LOAD, "mhpmevent3");
    write_csr(CSR_MCOUNTINHIBIT, 32'h0);
    n_instret = 0;
    n_load = 0;
    for (int i = 0; i < 48; i++) begin
      r = next_rand();
      @(negedge clk);
      hpm_event = '0;
      hpm_event[EVT_INSTRET] = r[3];
      hpm_event[EVT_LOAD] = r[9];
      hpm_event[EVT_STORE] = r[14];  // Not selected, must not count
      n_instret += r[3];
      n_load += r[9];
    end
    @(negedge clk);
    hpm_event = '0;
    write_csr(CSR_MCOUNTINHIBIT, 32'hD);  // Freeze all
    read64(CSR_MINSTRET, CSR_MINSTRETH, v64);
    check_word("minstret", start[1][31:0] + n_instret, v64[31:0]);
    check_word("minstreth", 32'((start[1] + 64'(n_instret)) >> 32), v64[63:32]);
    read64(CSR_MHPMCOUNTER3, CSR_MHPMCOUNTER3H, v64);
    check_word("mhpmcounter3", start[2][31:0] + n_load, v64[31:0]);
    check_word("mhpmcounter3h", 32'((start[2] + 64'(n_load)) >> 32), v64[63:32]);
    read64(CSR_MCYCLE, CSR_MCYCLEH, v64);
    read64(CSR_MCYCLE, CSR_MCYCLEH, v64b);
    assert (v64 > start[0]) else begin
      err_cnt++;
      $display("mcycle did not grow while it was enabled");
    end
    exp_cyc = start[0] + 64'd51;  // 51 enabled edges before the freeze
    check_word("mcycle", exp_cyc[31:0], v64[31:0]);
    check_word("mcycleh", exp_cyc[63:32], v64[63:32]);
    check_word("mcycle", exp_cyc[31:0], v64b[31:0]);  // Frozen by inhibit

    repeat (2) @(negedge clk);
    total = err_cnt + csr_top_inst.invariant_chk.fail_cnt;
    $display("Checks done: %0d value errors, %0d assertion failures, %0d total",
             err_cnt, csr_top_inst.invariant_chk.fail_cnt, total);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
design/csr_pkg.sv
design/csr_bus_if.sv
design/csr_access.sv
design/csr_trap_regs.sv
design/hpm_counter.sv
design/hpm_unit.sv
design/csr_top.sv
testbench/csr_tb_assert.sv
testbench/csr_tb.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  - files:
      - design/csr_pkg.sv
      - design/csr_bus_if.sv
      - design/csr_access.sv
      - design/csr_trap_regs.sv
      - design/hpm_counter.sv
      - design/hpm_unit.sv
      - design/csr_top.sv
  - target: test
    files:
      - testbench/csr_tb_assert.sv
      - testbench/csr_tb.sv
